// ==== filelist.f ====
+incdir+include
hdl/zports_pkg.sv
hdl/port_strobe.sv
hdl/ide_bridge.sv
hdl/sys_ports.sv
hdl/bus_readback.sv
hdl/zports_top.sv
verif/zports_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the io port testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
	--top-module zports_tb -f filelist.f -o zports_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/zports_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q -x "TEST OK" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verif/zports_tb.sv ====
//////////////////////////////
// directed testbench for the io port block
// drives z80 io cycles, checks ports, paging and the ide bridge
//////////////////////////////
`default_nettype none

module zports_tb
	import zports_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_CYCLES = 400; // about twice the test length

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [ 7:0] din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic        tape_read;
	logic [ 4:0] keys_in;
	logic [15:0] idein;
	logic [ 7:0] dout;
	logic        dataout;
	logic        porthit;
	ide_bus_t    ide;
	logic [ 3:0] border;
	logic [ 7:0] p7ffd;
	logic [ 7:0] peff7;
	logic [ 5:0] pent1m_page;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;
	logic        pent1m_rom;
	logic        romrw_en;
	logic        set_nmi;
	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] seed_val;

	zports_top zports_top_inst
	(
		.zclk (zclk), .rst_n (rst_n), .a (a), .din (din),
		.iorq_n (iorq_n), .rd_n (rd_n), .wr_n (wr_n), .dos (dos),
		.tape_read (tape_read), .keys_in (keys_in), .idein (idein),
		.dout (dout), .dataout (dataout), .porthit (porthit), .ide (ide),
		.border (border), .p7ffd (p7ffd), .peff7 (peff7), .pent1m_page (pent1m_page),
		.pent1m_1m_on (pent1m_1m_on), .pent1m_ram0_0 (pent1m_ram0_0),
		.pent1m_rom (pent1m_rom), .romrw_en (romrw_en), .set_nmi (set_nmi)
	);

	initial
	begin
		zclk = 1'b0;
		forever #4 zclk = ~zclk; // 8 ns period
	end

	// run limit
	always @(posedge zclk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ide(input string name, input ide_bus_t got, input ide_bus_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	// device side of a #10 access: cs0 selected, register 0
	function automatic ide_bus_t expected_ide(input logic [15:0] data, input logic rd_l,
		input logic wr_l);
		ide_bus_t e;
		e.dout    = data;
		e.a       = 3'b000;
		e.cs0_n   = 1'b0;
		e.cs1_n   = 1'b1;
		e.rd_n    = rd_l;
		e.wr_n    = wr_l;
		e.dataout = rd_l; // bridge drives unless the drive is read
		return e;
	endfunction

	//////////////////////////////
	// bus tasks, entered right after a rising edge
	//////////////////////////////
	task automatic io_read(input logic [15:0] addr, output logic [7:0] data,
		output logic hit, output logic oe, output ide_bus_t bus);
		#1;
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		@(posedge zclk);
		@(negedge zclk); // mid access, levels settled
		data = dout;
		hit  = porthit;
		oe   = dataout;
		bus  = ide;
		repeat (2) @(posedge zclk);
		#1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		repeat (2) @(posedge zclk); // idle gap
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data,
		output ide_bus_t bus);
		#1;
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		@(posedge zclk);
		@(negedge zclk);
		bus = ide;
		repeat (2) @(posedge zclk);
		#1;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (2) @(posedge zclk);
	endtask

	task automatic set_side_inputs(input logic dos_v, input logic [15:0] word_v);
		#1;
		dos   = dos_v;
		idein = word_v;
		@(posedge zclk);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic test_fe_port();
		logic [7:0] data;
		logic [7:0] val;
		logic       hit;
		logic       oe;
		ide_bus_t   bus;
		io_read(16'h00FE, data, hit, oe, bus);
		check_byte("fe dout", data, {1'b1, tape_read, 1'b0, keys_in});
		check_byte("fe porthit", {7'd0, hit}, 8'h01);
		check_byte("fe dataout", {7'd0, oe}, 8'h01);
		val = rand_byte();
		io_write(16'h00FE, val, bus); // a[3] high
		check_byte("border", {4'd0, border}, {5'b00000, val[2:0]});
		val = rand_byte();
		io_write(16'h12F6, val, bus); // alias, a[3] low
		check_byte("border", {4'd0, border}, {5'b00001, val[2:0]});
		io_read(16'h0001, data, hit, oe, bus);
		check_byte("idle dout", data, 8'hFF);
		check_byte("idle porthit", {7'd0, hit}, 8'h00);
		check_byte("idle dataout", {7'd0, oe}, 8'h00);
	endtask

	task automatic test_paging();
		logic [7:0] d;
		logic [7:0] e;
		ide_bus_t   bus;
		d = rand_byte();
		io_write(16'h7FFD, d, bus);
		check_byte("p7ffd", p7ffd, d);
		check_byte("pent1m_rom", {7'd0, pent1m_rom}, {7'd0, d[4]});
		d = rand_byte() | 8'h20; // lock bit
		io_write(16'h7FFD, d, bus);
		check_byte("pent1m_page", {2'b00, pent1m_page}, {2'b00, d[7:5], d[2:0]});
		e = rand_byte() | 8'h04; // 1 meg block
		io_write(16'hEFF7, e, bus);
		check_byte("p7ffd", p7ffd, {3'b000, d[4:0]});
		check_byte("peff7", peff7, e & 8'hB1);
		check_byte("pent1m_1m_on", {7'd0, pent1m_1m_on}, 8'h00);
		check_byte("pent1m_ram0_0", {7'd0, pent1m_ram0_0}, {7'd0, e[3]}); // raw bit
		io_write(16'h7FFD, ~d, bus); // locked out
		check_byte("p7ffd", p7ffd, {3'b000, d[4:0]});
		check_byte("pent1m_page", {2'b00, pent1m_page}, {2'b00, d[7:5], d[2:0]});
		check_byte("pent1m_rom", {7'd0, pent1m_rom}, {7'd0, d[4]});
		io_write(16'hEFF7, 8'h00, bus);
		check_byte("p7ffd", p7ffd, d);
		check_byte("pent1m_1m_on", {7'd0, pent1m_1m_on}, 8'h01);
		check_byte("pent1m_ram0_0", {7'd0, pent1m_ram0_0}, 8'h00);
	endtask

	task automatic test_config();
		logic [7:0] c;
		logic [7:0] e;
		logic [7:0] data;
		logic       hit;
		logic       oe;
		ide_bus_t   bus;
		c = rand_byte();
		io_write(16'h00BF, c, bus);
		io_read(16'h00BF, data, hit, oe, bus);
		check_byte("bf dout", data, {4'd0, c[3:0]});
		check_byte("romrw_en", {7'd0, romrw_en}, {7'd0, c[1]});
		check_byte("set_nmi", {7'd0, set_nmi}, {7'd0, c[3]});
		io_write(16'h00BF, 8'h00, bus);
		e = rand_byte() & 8'hFB; // keep block1m off
		io_write(16'hEFF7, e, bus);
		check_byte("peff7", peff7, e);
		io_write(16'h00BF, 8'h01, bus); // shadow_en
		io_write(16'hEFF7, ~e, bus);
		check_byte("peff7 shadow_en", peff7, e);
		io_read(16'hEFF7, data, hit, oe, bus);
		check_byte("f7 porthit", {7'd0, hit}, 8'h00);
		io_write(16'h00BF, 8'h00, bus);
		set_side_inputs(1'b1, idein); // dos
		io_write(16'hEFF7, ~e, bus);
		check_byte("peff7 dos", peff7, e);
		set_side_inputs(1'b0, idein);
	endtask

	task automatic test_ide_read_normal();
		logic [15:0] w;
		logic [ 7:0] data;
		logic        hit;
		logic        oe;
		ide_bus_t    bus;
		w = {rand_byte(), rand_byte()};
		set_side_inputs(1'b0, w);
		io_read(16'h0010, data, hit, oe, bus);
		check_byte("ide #10 dout", data, w[7:0]);
		check_ide("ide #10 read", bus, expected_ide({din, din}, 1'b0, 1'b1));
		set_side_inputs(1'b0, ~w); // captured byte must survive
		io_read(16'h0011, data, hit, oe, bus);
		check_byte("ide #11 dout", data, w[15:8]);
		check_byte("ide #11 porthit", {7'd0, hit}, 8'h01);
	endtask

	task automatic test_ide_read_divide();
		logic [15:0] w;
		logic [ 7:0] data;
		logic        hit;
		logic        oe;
		ide_bus_t    bus;
		w = {rand_byte(), rand_byte()};
		set_side_inputs(1'b0, w);
		io_read(16'h0010, data, hit, oe, bus);
		check_byte("ide 1st #10 dout", data, w[7:0]);
		set_side_inputs(1'b0, ~w);
		io_read(16'h0010, data, hit, oe, bus); // no device cycle
		check_byte("ide 2nd #10 dout", data, w[15:8]);
		check_ide("ide 2nd #10 read", bus, expected_ide({din, din}, 1'b1, 1'b1));
	endtask

	task automatic test_ide_write();
		logic [7:0] b1;
		logic [7:0] b2;
		ide_bus_t   bus;
		b1 = rand_byte();
		b2 = rand_byte();
		io_write(16'h0011, b1, bus); // normal, high byte first
		io_write(16'h0010, b2, bus);
		check_word("ide.dout normal", bus.dout, {b1, b2});
		check_ide("ide normal write", bus, expected_ide({b1, b2}, 1'b1, 1'b0));
		b1 = rand_byte();
		b2 = rand_byte();
		io_write(16'h0010, b1, bus); // divide, held back
		check_ide("ide divide 1st write", bus, expected_ide({b1, b1}, 1'b1, 1'b1));
		io_write(16'h0010, b2, bus);
		check_word("ide.dout divide", bus.dout, {b2, b1});
		check_ide("ide divide 2nd write", bus, expected_ide({b2, b1}, 1'b1, 1'b0));
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial
	begin
		seed_val  = $urandom(51362);
		errors    = 0;
		checks    = 0;
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		tape_read = seed_val[5];
		keys_in   = seed_val[4:0];
		idein     = 16'h0000;
		repeat (4) @(posedge zclk);
		#1 rst_n = 1'b1;
		@(posedge zclk);
		test_fe_port();
		test_paging();
		test_config();
		test_ide_read_normal();
		test_ide_read_divide();
		test_ide_write();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/zports_top.sv ====
//////////////////////////////
// io port block top level
// strobes feed the ide bridge and system registers, readback muxes the results
//////////////////////////////
`default_nettype none

module zports_top
	import zports_pkg::*;
(
	input  wire         zclk,
	input  wire         rst_n,
	input  wire  [15:0] a,
	input  wire  [ 7:0] din,
	input  wire         iorq_n,
	input  wire         rd_n,
	input  wire         wr_n,
	input  wire         dos,
	input  wire         tape_read,
	input  wire  [ 4:0] keys_in,
	input  wire  [15:0] idein,
	output logic [ 7:0] dout,
	output logic        dataout,
	output logic        porthit,
	output ide_bus_t    ide,
	output logic [ 3:0] border,
	output logic [ 7:0] p7ffd,
	output logic [ 7:0] peff7,
	output logic [ 5:0] pent1m_page,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        pent1m_rom,
	output logic        romrw_en,
	output logic        set_nmi
);

	z_bus_t     zbus;
	paging_t    paging;
	sys_cfg_t   cfg;
	logic       shadow;
	logic [7:0] ide_rd_data;

	port_strobe port_strobe_inst
	(
		.zclk   (zclk),
		.rst_n  (rst_n),
		.a      (a),
		.din    (din),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.zbus   (zbus)
	);

	ide_bridge ide_bridge_inst
	(
		.zclk        (zclk),
		.rst_n       (rst_n),
		.zbus        (zbus),
		.idein       (idein),
		.ide         (ide),
		.ide_rd_data (ide_rd_data)
	);

	sys_ports sys_ports_inst
	(
		.zclk          (zclk),
		.rst_n         (rst_n),
		.zbus          (zbus),
		.dos           (dos),
		.border        (border),
		.paging        (paging),
		.cfg           (cfg),
		.shadow        (shadow),
		.pent1m_page   (pent1m_page),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.pent1m_rom    (pent1m_rom)
	);

	bus_readback bus_readback_inst
	(
		.zbus        (zbus),
		.paging      (paging),
		.cfg         (cfg),
		.shadow      (shadow),
		.tape_read   (tape_read),
		.keys_in     (keys_in),
		.ide_rd_data (ide_rd_data),
		.dout        (dout),
		.porthit     (porthit),
		.dataout     (dataout)
	);

	// unpack records onto the board pins
	assign p7ffd    = paging.p7ffd;
	assign peff7    = paging.peff7;
	assign romrw_en = cfg.romrw_en;
	assign set_nmi  = cfg.set_nmi;

endmodule

`default_nettype wire

// ==== hdl/bus_readback.sv ====
//////////////////////////////
// port hit decode and cpu read data mux
// purely combinational, drives dout/dataout to the z80 bus
//////////////////////////////
`default_nettype none

`include "zports_consts.svh"

module bus_readback
	import zports_pkg::*;
(
	input  z_bus_t      zbus,
	input  paging_t     paging,
	input  sys_cfg_t    cfg,
	input  wire         shadow,
	input  wire         tape_read,
	input  wire  [ 4:0] keys_in,
	input  wire  [ 7:0] ide_rd_data,
	output logic [ 7:0] dout,
	output logic        porthit,
	output logic        dataout
);

	logic [7:0] loa;
	logic       ext_port;  // FFFD, served outside

	assign loa = zbus.addr[7:0];

	// internal ports
	always_comb
	begin
		case (loa)
			`ZP_PORT_FE, `ZP_PORT_F6, `ZP_PORT_FD, `ZP_PORT_BF,
			`ZP_IDE_10, `ZP_IDE_11, `ZP_IDE_30, `ZP_IDE_50, `ZP_IDE_70,
			`ZP_IDE_90, `ZP_IDE_B0, `ZP_IDE_D0, `ZP_IDE_F0, `ZP_IDE_C8:
				porthit = 1'b1;
			`ZP_PORT_F7:
				porthit = ~shadow;
			default:
				porthit = 1'b0;
		endcase
	end

	assign ext_port = (loa == `ZP_PORT_FD) & (zbus.addr[15:14] == 2'b11);
	assign dataout  = porthit & ~zbus.iorq_n & ~zbus.rd_n & ~ext_port;

	////////////////////////////////
	// read data
	////////////////////////////////
	always_comb
	begin
		case (loa)
			`ZP_PORT_FE, `ZP_PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			`ZP_IDE_10, `ZP_IDE_11, `ZP_IDE_30, `ZP_IDE_50, `ZP_IDE_70,
			`ZP_IDE_90, `ZP_IDE_B0, `ZP_IDE_D0, `ZP_IDE_F0, `ZP_IDE_C8:
				dout = ide_rd_data;
			`ZP_PORT_BF:
				dout = {4'b0000, cfg};  // nmi, font, romrw, shadow
			`ZP_PORT_F7:
				// EFF7 readback, same address window as the write
				if (!shadow && zbus.addr[8] && !zbus.addr[12])
					dout = paging.peff7;
				else
					dout = `ZP_IDLE_BYTE;
			default:
				dout = `ZP_IDLE_BYTE;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/sys_ports.sv ====
//////////////////////////////
// border, 7FFD, EFF7 and xxBF registers
// also derives the pentagon-1m paging outputs
//////////////////////////////
`default_nettype none

`include "zports_consts.svh"

module sys_ports
	import zports_pkg::*;
(
	input  wire         zclk,
	input  wire         rst_n,
	input  z_bus_t      zbus,
	input  wire         dos,
	output logic [ 3:0] border,
	output paging_t     paging,
	output sys_cfg_t    cfg,
	output logic        shadow,
	output logic [ 5:0] pent1m_page,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        pent1m_rom
);

	logic [7:0] loa;
	logic       fe_wr;       // FE/F6 write
	logic       fd_wr;       // 7FFD write
	logic       f7_wr;       // EFF7 write
	logic       bf_wr;       // xxBF write
	logic [7:0] p7ffd_r;     // raw 7FFD
	logic [7:0] peff7_r;     // raw EFF7
	logic       block1m;
	logic       block7ffd;

	assign loa = zbus.addr[7:0];

	assign fe_wr = zbus.port_wr & ((loa == `ZP_PORT_FE) | (loa == `ZP_PORT_F6));
	assign fd_wr = zbus.port_wr & (loa == `ZP_PORT_FD) & ~zbus.addr[15];
	assign f7_wr = zbus.port_wr & (loa == `ZP_PORT_F7) & zbus.addr[8] & ~zbus.addr[12]
		& ~shadow;                                 // EFF7 hidden in shadow mode
	assign bf_wr = zbus.port_wr & (loa == `ZP_PORT_BF);

	assign shadow    = dos | cfg.shadow_en;
	assign block1m   = peff7_r[`ZP_BLK1M_BIT];
	assign block7ffd = p7ffd_r[`ZP_LOCK48_BIT] & block1m; // 48k lock

	////////////////////////////////
	// registers
	////////////////////////////////
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= `ZP_BORDER_RST;
		else if (fe_wr)
			border <= {~zbus.addr[3], zbus.din[2:0]};
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_r <= `ZP_PAGE_RST;
		else if (fd_wr && !block7ffd)
			p7ffd_r <= zbus.din;  // 2..0 page, 3 screen, 4 rom, 5 lock
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_r <= `ZP_PAGE_RST;
		else if (f7_wr)
			peff7_r <= zbus.din;  // 2 block1m, 3 ram0
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			cfg <= `ZP_CFG_RST;
		else if (bf_wr)
			cfg <= zbus.din[3:0];
	end

	////////////////////////////////
	// derived outputs
	////////////////////////////////

	// paging as seen by the memory side, 1m bits masked off in block1m
	always_comb
	begin
		paging.p7ffd = {(block1m ? 3'b000 : p7ffd_r[7:5]), p7ffd_r[4:0]};
		if (block1m)
			paging.peff7 = {peff7_r[7], 1'b0, peff7_r[5:4], 3'b000, peff7_r[0]};
		else
			paging.peff7 = peff7_r;
	end

	assign pent1m_page   = {p7ffd_r[7:5], p7ffd_r[2:0]};  // full 1m page
	assign pent1m_1m_on  = ~peff7_r[`ZP_BLK1M_BIT];
	assign pent1m_ram0_0 = peff7_r[`ZP_RAM0_BIT];
	assign pent1m_rom    = p7ffd_r[`ZP_ROM_BIT];

endmodule

`default_nettype wire

// ==== hdl/ide_bridge.sv ====
//////////////////////////////
// 16-bit ide data bridge for the 8-bit bus
// handles normal #10/#11 and nemo-divide #10/#10 byte order
//////////////////////////////
`default_nettype none

`include "zports_consts.svh"

module ide_bridge
	import zports_pkg::*;
(
	input  wire         zclk,
	input  wire         rst_n,
	input  z_bus_t      zbus,
	input  wire  [15:0] idein,
	output ide_bus_t    ide,
	output logic [ 7:0] ide_rd_data
);

	logic [7:0]  loa;
	logic        ide_ports;     // physical device ports
	logic        ide_access;    // any ide port, incl #11, strobed
	logic        is_10;
	logic        is_11;

	logic        rd_trig;       // divide read trigger
	logic        wrlo_trig;     // divide write triggers
	logic        wrhi_trig;
	logic        rd_copy;       // trigger copies, frozen during an access
	logic        wrlo_copy;
	logic        wrhi_copy;

	logic [ 7:0] hi_in;         // high byte of the last #10 read
	logic [15:0] wr_reg;        // pre-written half of a word

	assign loa   = zbus.addr[7:0];
	assign is_10 = (loa == `ZP_IDE_10);
	assign is_11 = (loa == `ZP_IDE_11);

	always_comb
	begin
		case (loa)
			`ZP_IDE_10, `ZP_IDE_30, `ZP_IDE_50, `ZP_IDE_70, `ZP_IDE_90,
			`ZP_IDE_B0, `ZP_IDE_D0, `ZP_IDE_F0, `ZP_IDE_C8:
				ide_ports = 1'b1;
			default:
				ide_ports = 1'b0;
		endcase
	end

	assign ide_access = (ide_ports | is_11) & (zbus.port_rd | zbus.port_wr);

	////////////////////////////////
	// triggers
	////////////////////////////////
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_trig   <= 1'b0;
			wrlo_trig <= 1'b0;
			wrhi_trig <= 1'b0;
		end
		else if (ide_access)
		begin
			rd_trig   <= is_10 & zbus.port_rd & ~rd_trig;  // first #10 read
			wrhi_trig <= is_11 & zbus.port_wr;             // #11 write
			wrlo_trig <= is_10 & zbus.port_wr & ~wrhi_trig & ~wrlo_trig;
		end
	end

	// copies only move while the bus is idle
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_copy   <= 1'b0;
			wrlo_copy <= 1'b0;
			wrhi_copy <= 1'b0;
		end
		else
		begin
			if (zbus.rd_n)
				rd_copy <= rd_trig;
			if (zbus.wr_n)
			begin
				wrlo_copy <= wrlo_trig;
				wrhi_copy <= wrhi_trig;
			end
		end
	end

	////////////////////////////////
	// data registers
	////////////////////////////////
	always_ff @(posedge zclk)
	begin
		if (zbus.port_rd && is_10 && !rd_trig)
			hi_in <= idein[15:8];
		if (zbus.port_wr && is_11)
			wr_reg[15:8] <= zbus.din;
		if (zbus.port_wr && is_10 && !wrlo_trig)
			wr_reg[7:0] <= zbus.din;
	end

	// device side
	always_comb
	begin
		ide.a     = zbus.addr[7:5];
		ide.cs0_n = ~ide_ports | (loa == `ZP_IDE_C8);
		ide.cs1_n = ~ide_ports | (loa != `ZP_IDE_C8);
		ide.rd_n  = zbus.iorq_n | zbus.rd_n | ~ide_ports | (rd_copy & is_10); // no 2nd read
		ide.wr_n  = zbus.iorq_n | zbus.wr_n | ~ide_ports | (is_10 & ~wrlo_copy & ~wrhi_copy);
		ide.dout[15:8] = wrhi_copy ? wr_reg[15:8] : zbus.din;
		ide.dout[ 7:0] = wrlo_copy ? wr_reg[ 7:0] : zbus.din;
		ide.dataout    = ide.rd_n; // drive only when not reading
	end

	// cpu read data
	assign ide_rd_data = (is_11 || (is_10 && rd_copy)) ? hi_in : idein[7:0];

endmodule

`default_nettype wire

// ==== hdl/port_strobe.sv ====
//////////////////////////////
// z80 io strobe generator
// one-cycle port_rd/port_wr per io access, packed with the bus levels
//////////////////////////////
`default_nettype none

module port_strobe
	import zports_pkg::*;
(
	input  wire         zclk,
	input  wire         rst_n,
	input  wire  [15:0] a,
	input  wire  [ 7:0] din,
	input  wire         iorq_n,
	input  wire         rd_n,
	input  wire         wr_n,
	output z_bus_t      zbus
);

	logic io_wr_lvl;  // io write in progress
	logic io_rd_lvl;  // io read in progress
	logic iowr_prev;  // level seen at the last edge
	logic iord_prev;
	logic port_wr_q;
	logic port_rd_q;

	assign io_wr_lvl = ~(iorq_n | wr_n);
	assign io_rd_lvl = ~(iorq_n | rd_n);

	// rising edge of the access level, sampled on zclk
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_prev <= 1'b0;
			iord_prev <= 1'b0;
			port_wr_q <= 1'b0;
			port_rd_q <= 1'b0;
		end
		else
		begin
			iowr_prev <= io_wr_lvl;
			iord_prev <= io_rd_lvl;
			port_wr_q <= io_wr_lvl & ~iowr_prev; // first edge only
			port_rd_q <= io_rd_lvl & ~iord_prev;
		end
	end

	// bus record, levels pass straight through
	always_comb
	begin
		zbus.addr    = a;
		zbus.din     = din;
		zbus.iorq_n  = iorq_n;
		zbus.rd_n    = rd_n;
		zbus.wr_n    = wr_n;
		zbus.port_rd = port_rd_q;
		zbus.port_wr = port_wr_q;
	end

endmodule

`default_nettype wire

// ==== hdl/zports_pkg.sv ====
//////////////////////////////
// bus, ide and paging record types
// imported by every port block
//////////////////////////////
`default_nettype none

package zports_pkg;

	// z80 side, one sampled bus view
	typedef struct packed
	{
		logic [15:0] addr;    // full port address
		logic [ 7:0] din;     // write data from cpu
		logic        iorq_n;  // raw levels
		logic        rd_n;
		logic        wr_n;
		logic        port_rd; // one-cycle strobes
		logic        port_wr;
	} z_bus_t;

	// ide device side
	typedef struct packed
	{
		logic [15:0] dout;    // data to the drive
		logic [ 2:0] a;       // task file register
		logic        cs0_n;
		logic        cs1_n;
		logic        rd_n;
		logic        wr_n;
		logic        dataout; // 1 = drive the data bus
	} ide_bus_t;

	// memory paging registers
	typedef struct packed
	{
		logic [7:0] p7ffd;
		logic [7:0] peff7;
	} paging_t;

	// xxBF config bits, msb first as on the bus
	typedef struct packed
	{
		logic set_nmi;   // bit 3
		logic fntw_en;   // bit 2
		logic romrw_en;  // bit 1
		logic shadow_en; // bit 0
	} sys_cfg_t;

endpackage

`default_nettype wire

// ==== include/zports_consts.svh ====
//////////////////////////////
// port addresses, reset values and register bit positions
// included by the port decoders and the register block
//////////////////////////////
`ifndef ZPORTS_CONSTS_SVH
`define ZPORTS_CONSTS_SVH

// speccy ports, low address byte
`define ZP_PORT_FE 8'hFE // keyboard / border
`define ZP_PORT_F6 8'hF6 // alias of FE
`define ZP_PORT_FD 8'hFD // 7FFD paging
`define ZP_PORT_F7 8'hF7 // EFF7 paging
`define ZP_PORT_BF 8'hBF // xxBF config

// nemo ide ports
`define ZP_IDE_10 8'h10 // data, low byte
`define ZP_IDE_11 8'h11 // data, high byte (not a device port)
`define ZP_IDE_30 8'h30
`define ZP_IDE_50 8'h50
`define ZP_IDE_70 8'h70
`define ZP_IDE_90 8'h90
`define ZP_IDE_B0 8'hB0
`define ZP_IDE_D0 8'hD0
`define ZP_IDE_F0 8'hF0
`define ZP_IDE_C8 8'hC8 // control block, goes to cs1

`define ZP_IDLE_BYTE 8'hFF // floating bus read

// reset values
`define ZP_BORDER_RST 4'h0
`define ZP_PAGE_RST   8'h00
`define ZP_CFG_RST    4'h0

// register bit positions
`define ZP_LOCK48_BIT 5 // 7FFD, 48k lock
`define ZP_ROM_BIT    4 // 7FFD, rom select
`define ZP_RAM0_BIT   3 // EFF7, ram in page 0
`define ZP_BLK1M_BIT  2 // EFF7, 1 meg block

`endif
